/* design/clock_defs.svh */
`ifndef CLOCK_DEFS_SVH
`define CLOCK_DEFS_SVH

// ==============================
// timing constants
// ==============================

// number of CLK cycles between two tick strobes.
// a real board would divide down to one tick per second.
`define CLOCK_TICK_DIV 8

// cycles the synchronized key must stay high before a press is taken.
`define CLOCK_KEY_STABLE 3

`endif

/* design/clock_pkg.sv */
`default_nettype none

package clock_pkg;

  // ==============================
  // digit groups
  // ==============================

  typedef struct packed {
    logic [2:0] tens;   // 0 to 5.
    logic [3:0] units;  // 0 to 9.
  } digit60_t;          // one minutes or seconds value, 7 bits.

  typedef struct packed {
    logic [1:0] tens;   // 0 to 2.
    logic [3:0] units;  // 0 to 9, or 0 to 3 in the twenties.
  } digit24_t;          // one hour value, 6 bits.

  typedef struct packed {
    digit24_t hour;     // most significant, so the word reads hh:mm:ss.
    digit60_t min;
    digit60_t sec;
  } clock_time_t;       // full time or alarm value, 20 bits.

  // ==============================
  // setting controls
  // ==============================

  typedef enum logic [1:0] {
    UNIT_SEC  = 2'd0,   // key works on the seconds counter.
    UNIT_MIN  = 2'd1,   // key works on the minutes counter.
    UNIT_HOUR = 2'd2    // key works on the hours counter.
  } unit_sel_t;

  typedef struct packed {
    logic      run;       // 1 counts ticks, 0 stops the clock for setting.
    unit_sel_t unit;      // counter whose time digits the key steps.
    logic      adj_tens;  // key steps the tens digit.
    logic      adj_units; // key steps the units digit.
  } set_ctrl_t;

  typedef struct packed {
    logic      on;        // alarm enabled.
    unit_sel_t unit;      // counter whose alarm digits the key steps.
    logic      adj_tens;
    logic      adj_units;
  } alarm_ctrl_t;

  typedef struct packed {
    logic run;            // copy of set_ctrl.run for every counter.
    logic time_tens;      // key steps this counter's time tens digit.
    logic time_units;     // key steps this counter's time units digit.
    logic alarm_tens;     // key steps this counter's alarm tens digit.
    logic alarm_units;    // key steps this counter's alarm units digit.
  } digit_key_t;          // per-counter decode made in clock_top.

endpackage

`default_nettype wire

/* design/tick_prescaler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "clock_defs.svh"

module tick_prescaler (
  input  wire  CLK,
  input  wire  RESET,
  output logic tick
);

  localparam int CNT_W = $clog2(`CLOCK_TICK_DIV + 1); // wide enough for the last count.
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`CLOCK_TICK_DIV - 1); // count just before wrap.

  logic [CNT_W-1:0] cnt; // cycles since the last tick.

  // the count wraps every CLOCK_TICK_DIV cycles and the tick flop marks that cycle.
  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      cnt  <= '0;   // first tick comes CLOCK_TICK_DIV cycles after reset.
      tick <= 1'b0;
    end
    else if (cnt == LAST)
    begin
      cnt  <= '0;   // wrap back to the start of the period.
      tick <= 1'b1; // one cycle strobe while the count reads zero.
    end
    else
    begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/key_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

`include "clock_defs.svh"

module key_pulse (
  input  wire  CLK,
  input  wire  RESET,
  input  wire  key,
  output logic key_strobe
);

  localparam int CNT_W = $clog2(`CLOCK_KEY_STABLE + 1);           // holds 0 to STABLE.
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`CLOCK_KEY_STABLE - 1); // final stable cycle.

  logic             key_meta;  // first synchronizer flop.
  logic             key_sync;  // second synchronizer flop, safe to use.
  logic [CNT_W-1:0] stable_cnt; // cycles the synchronized key has been high.
  logic             armed;     // cleared after a strobe until the key is let go.

  // two flop synchronizer for the raw button level.
  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      key_meta <= 1'b0;
      key_sync <= 1'b0;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ==============================
  // debounce and one shot
  // ==============================

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      stable_cnt <= '0;
      armed      <= 1'b1;
      key_strobe <= 1'b0;
    end
    else if (!key_sync)
    begin
      stable_cnt <= '0;   // any low cycle restarts the stability count.
      armed      <= 1'b1; // a released key may fire again.
      key_strobe <= 1'b0;
    end
    else if (armed && (stable_cnt == LAST))
    begin
      armed      <= 1'b0; // holding the key gives no second strobe.
      key_strobe <= 1'b1; // fires 2 + CLOCK_KEY_STABLE cycles after the press.
    end
    else
    begin
      if (armed)
      begin
        stable_cnt <= stable_cnt + 1'b1; // still counting toward a press.
      end
      key_strobe <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/base60_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module base60_counter (
  input  wire                     CLK,
  input  wire                     RESET,
  input  wire                     cin,         // tick or carry from the stage below.
  input  wire                     key_strobe,  // one cycle per debounced press.
  input  wire clock_pkg::digit_key_t keys,     // run flag and digit selects.
  output clock_pkg::digit60_t     value,       // running minutes or seconds.
  output clock_pkg::digit60_t     alarm_value, // alarm minutes or seconds.
  output logic                    cout         // carry into the next stage.
);

  logic units_carry; // units digit rolls over on this carry-in.

  // steps the chosen digits once, each wrapping on its own without any carry.
  function automatic clock_pkg::digit60_t step_digits(input clock_pkg::digit60_t d,
                                                      input logic do_tens,
                                                      input logic do_units);
    clock_pkg::digit60_t r;
    r = d;
    if (do_tens)
    begin
      r.tens = (d.tens == 3'd5) ? 3'd0 : d.tens + 3'd1; // tens wrap 5 to 0.
    end
    if (do_units)
    begin
      r.units = (d.units == 4'd9) ? 4'd0 : d.units + 4'd1; // units wrap 9 to 0.
    end
    return r;
  endfunction

  // carries are combinational so a full wrap ripples through all stages in one clock.
  assign units_carry = cin && (value.units == 4'd9);
  assign cout        = units_carry && (value.tens == 3'd5); // last value is 59.

  // ==============================
  // running time digits
  // ==============================

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      value <= '0;
    end
    else if (keys.run)
    begin
      if (cin)
      begin
        value <= step_digits(value, units_carry, 1'b1); // tens follow the units carry.
      end
    end
    else if (key_strobe)
    begin
      value <= step_digits(value, keys.time_tens, keys.time_units); // set while stopped.
    end
  end

  // ==============================
  // alarm digits
  // ==============================

  // the alarm can be set at any time, running or not.
  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      alarm_value <= '0;
    end
    else if (key_strobe)
    begin
      alarm_value <= step_digits(alarm_value, keys.alarm_tens, keys.alarm_units);
    end
  end

endmodule

`default_nettype wire

/* design/base24_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module base24_counter (
  input  wire                     CLK,
  input  wire                     RESET,
  input  wire                     cin,         // carry out of the minutes stage.
  input  wire                     key_strobe,  // one cycle per debounced press.
  input  wire clock_pkg::digit_key_t keys,     // run flag and digit selects.
  output clock_pkg::digit24_t     value,       // running hours.
  output clock_pkg::digit24_t     alarm_value  // alarm hours.
);

  // one hour forward, 23 wraps to 00.
  function automatic clock_pkg::digit24_t advance(input clock_pkg::digit24_t d);
    clock_pkg::digit24_t r;
    r = d;
    if ((d.tens == 2'd2) && (d.units == 4'd3))
    begin
      r = '0; // end of the day.
    end
    else if (d.units == 4'd9)
    begin
      r.units = 4'd0;
      r.tens  = d.tens + 2'd1; // 09 to 10 and 19 to 20.
    end
    else
    begin
      r.units = d.units + 4'd1;
    end
    return r;
  endfunction

  // key step, tens first and then units on the result when both are chosen.
  function automatic clock_pkg::digit24_t step_digits(input clock_pkg::digit24_t d,
                                                      input logic do_tens,
                                                      input logic do_units);
    clock_pkg::digit24_t r;
    logic [3:0]          top_units; // last units value allowed under the current tens.
    r = d;
    if (do_tens)
    begin
      r.tens = (d.tens == 2'd2) ? 2'd0 : d.tens + 2'd1; // tens wrap 2 to 0.
      if ((r.tens == 2'd2) && (d.units > 4'd3))
      begin
        r.units = 4'd3; // clamp so the hour never passes 23.
      end
    end
    top_units = (r.tens == 2'd2) ? 4'd3 : 4'd9;
    if (do_units)
    begin
      r.units = (r.units >= top_units) ? 4'd0 : r.units + 4'd1; // no carry into tens.
    end
    return r;
  endfunction

  // ==============================
  // running time and alarm hours
  // ==============================

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      value <= '0;
    end
    else if (keys.run)
    begin
      if (cin)
      begin
        value <= advance(value); // carry from 59:59.
      end
    end
    else if (key_strobe)
    begin
      value <= step_digits(value, keys.time_tens, keys.time_units);
    end
  end

  // same wrap and clamp rules for the alarm, which is settable while running.
  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      alarm_value <= '0;
    end
    else if (key_strobe)
    begin
      alarm_value <= step_digits(alarm_value, keys.alarm_tens, keys.alarm_units);
    end
  end

endmodule

`default_nettype wire

/* design/alarm_match.sv */
`timescale 1ns/1ps
`default_nettype none

module alarm_match (
  input  wire                      CLK,
  input  wire                      RESET,
  input  wire                      on,         // alarm enable from the user.
  input  wire clock_pkg::clock_time_t time_now,   // current time.
  input  wire clock_pkg::clock_time_t alarm_time, // programmed alarm time.
  output logic                     ring        // high while the times agree.
);

  logic match; // all twenty bits of the two times are equal.

  // a full hh:mm:ss compare, so the ring lasts exactly one second of clock time.
  assign match = (time_now == alarm_time);

  // registered so ring is a clean flop output, one cycle behind the compare.
  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      ring <= 1'b0;
    end
    else
    begin
      ring <= on && match; // disabled alarm keeps ring low.
    end
  end

endmodule

`default_nettype wire

/* design/clock_top.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_top (
  input  wire                      CLK,
  input  wire                      RESET,
  input  wire                      key,        // raw push button level.
  input  wire clock_pkg::set_ctrl_t   set_ctrl,   // time setting controls.
  input  wire clock_pkg::alarm_ctrl_t alarm_ctrl, // alarm setting controls.
  output clock_pkg::clock_time_t   time_now,
  output clock_pkg::clock_time_t   alarm_time,
  output logic                     ring
);

  logic                  tick;        // one cycle per CLOCK_TICK_DIV cycles.
  logic                  key_strobe;  // one cycle per press.
  logic                  sec_cout;    // seconds roll from 59 to 00.
  logic                  min_cout;    // minutes roll from 59 to 00.
  clock_pkg::digit_key_t sec_keys;
  clock_pkg::digit_key_t min_keys;
  clock_pkg::digit_key_t hour_keys;

  // routes the adjust bits to the counter named by each unit select.
  function automatic clock_pkg::digit_key_t decode_keys(input clock_pkg::unit_sel_t u,
                                                        input clock_pkg::set_ctrl_t s,
                                                        input clock_pkg::alarm_ctrl_t a);
    clock_pkg::digit_key_t k;
    logic                  time_hit;  // time setting targets this counter.
    logic                  alarm_hit; // alarm setting targets this counter.
    time_hit      = !s.run && (s.unit == u); // time digits only move while stopped.
    alarm_hit     = (a.unit == u);
    k.run         = s.run;
    k.time_tens   = time_hit && s.adj_tens;
    k.time_units  = time_hit && s.adj_units;
    k.alarm_tens  = alarm_hit && a.adj_tens;
    k.alarm_units = alarm_hit && a.adj_units;
    return k;
  endfunction

  assign sec_keys  = decode_keys(clock_pkg::UNIT_SEC, set_ctrl, alarm_ctrl);
  assign min_keys  = decode_keys(clock_pkg::UNIT_MIN, set_ctrl, alarm_ctrl);
  assign hour_keys = decode_keys(clock_pkg::UNIT_HOUR, set_ctrl, alarm_ctrl);

  // ==============================
  // strobes and counter chain
  // ==============================

  tick_prescaler u_tick_prescaler (
    .CLK   (CLK),
    .RESET (RESET),
    .tick  (tick)
  );

  key_pulse u_key_pulse (
    .CLK        (CLK),
    .RESET      (RESET),
    .key        (key),
    .key_strobe (key_strobe)
  );

  base60_counter u_sec_counter ( // tick is the carry-in of the chain.
    .CLK (CLK), .RESET (RESET), .cin (tick), .key_strobe (key_strobe), .keys (sec_keys),
    .value (time_now.sec), .alarm_value (alarm_time.sec), .cout (sec_cout)
  );

  base60_counter u_min_counter (
    .CLK (CLK), .RESET (RESET), .cin (sec_cout), .key_strobe (key_strobe), .keys (min_keys),
    .value (time_now.min), .alarm_value (alarm_time.min), .cout (min_cout)
  );

  base24_counter u_hour_counter (
    .CLK (CLK), .RESET (RESET), .cin (min_cout), .key_strobe (key_strobe), .keys (hour_keys),
    .value (time_now.hour), .alarm_value (alarm_time.hour)
  );

  alarm_match u_alarm_match (
    .CLK        (CLK),
    .RESET      (RESET),
    .on         (alarm_ctrl.on),
    .time_now   (time_now),
    .alarm_time (alarm_time),
    .ring       (ring)
  );

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic RESET
);

  // free running clock with a 4 ns period.
  initial
  begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // reset covers eight rising edges and drops just after the last one.
  initial
  begin
    RESET = 1'b1;
    repeat (8) @(posedge CLK);
    #1 RESET = 1'b0;
  end

endmodule

`default_nettype wire

/* test/tb_clock_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "clock_defs.svh"

module tb_clock_top;

  localparam int DIV          = `CLOCK_TICK_DIV;
  localparam int TICK_BUDGET  = 110; // ticks waited for over all tests, with some slack.
  localparam int PRESS_BUDGET = 50;  // key presses over all tests, with some slack.
  localparam int LIMIT        = TICK_BUDGET * DIV + PRESS_BUDGET * 20 + 200;

  logic                   CLK;
  logic                   RESET;
  logic                   key;
  clock_pkg::set_ctrl_t   set_ctrl;
  clock_pkg::alarm_ctrl_t alarm_ctrl;
  clock_pkg::clock_time_t time_now;
  clock_pkg::clock_time_t alarm_time;
  logic                   ring;

  clock_pkg::clock_time_t exp_time;   // model of time_now.
  clock_pkg::clock_time_t exp_alarm;  // model of alarm_time.
  logic                   exp_ring;   // model of ring.
  logic                   tick_now;   // model says a tick lands on this edge.
  logic                   strobe_now; // model says a key step lands on this edge.
  int run_cycles;  // edges since reset fell.
  int key_high;    // edges in a row that saw the key high.
  int ticks_seen;
  int cycles;
  int checks;
  int errors;
  int errors_mark; // error count when the current test began.

  tb_clock_gen u_tb_clock_gen (
    .CLK   (CLK),
    .RESET (RESET)
  );

  clock_top u_clock_top (
    .CLK        (CLK),
    .RESET      (RESET),
    .key        (key),
    .set_ctrl   (set_ctrl),
    .alarm_ctrl (alarm_ctrl),
    .time_now   (time_now),
    .alarm_time (alarm_time),
    .ring       (ring)
  );

  // ==============================
  // reference model
  // ==============================

  function automatic clock_pkg::clock_time_t make_time(input int h, input int m, input int s);
    clock_pkg::clock_time_t r;
    r.hour.tens  = 2'(h / 10);
    r.hour.units = 4'(h % 10);
    r.min.tens   = 3'(m / 10);
    r.min.units  = 4'(m % 10);
    r.sec.tens   = 3'(s / 10);
    r.sec.units  = 4'(s % 10);
    return r;
  endfunction

  function automatic clock_pkg::digit60_t step60(input clock_pkg::digit60_t d,
                                                 input logic dt, input logic du);
    clock_pkg::digit60_t r;
    r = d;
    if (dt) r.tens = 3'((int'(d.tens) + 1) % 6);   // tens roll 5 to 0.
    if (du) r.units = 4'((int'(d.units) + 1) % 10); // units roll 9 to 0.
    return r;
  endfunction

  function automatic clock_pkg::digit24_t step24(input clock_pkg::digit24_t d,
                                                 input logic dt, input logic du);
    int ht;
    int hu;
    ht = int'(d.tens);
    hu = int'(d.units);
    if (dt)
    begin
      ht = (ht + 1) % 3;
      if ((ht == 2) && (hu > 3)) hu = 3; // no hour above 23.
    end
    if (du) hu = (ht == 2) ? (hu + 1) % 4 : (hu + 1) % 10;
    return '{tens: 2'(ht), units: 4'(hu)};
  endfunction

  // one clock edge of a time or alarm value, from the tick, carry and step rules.
  function automatic clock_pkg::clock_time_t next_time(input clock_pkg::clock_time_t t,
      input logic do_tick, input logic run, input logic strobe,
      input clock_pkg::unit_sel_t unit, input logic dt, input logic du);
    clock_pkg::clock_time_t r;
    int secs;
    r = t;
    if (run && do_tick)
    begin
      secs = (int'(t.hour.tens) * 10 + int'(t.hour.units)) * 3600
           + (int'(t.min.tens) * 10 + int'(t.min.units)) * 60
           + int'(t.sec.tens) * 10 + int'(t.sec.units);
      secs = (secs + 1) % 86400; // whole day wraps at once.
      r = make_time(secs / 3600, (secs / 60) % 60, secs % 60);
    end
    else if (!run && strobe)
    begin
      case (unit)
        clock_pkg::UNIT_SEC:  r.sec  = step60(t.sec, dt, du);
        clock_pkg::UNIT_MIN:  r.min  = step60(t.min, dt, du);
        clock_pkg::UNIT_HOUR: r.hour = step24(t.hour, dt, du);
        default:              r      = t;
      endcase
    end
    return r;
  endfunction

  always @(posedge CLK)
  begin
    if (RESET)
    begin
      exp_time   = '0;
      exp_alarm  = '0;
      exp_ring   = 1'b0;
      run_cycles = 0;
      key_high   = 0;
      ticks_seen = 0;
    end
    else
    begin
      run_cycles = run_cycles + 1;
      tick_now   = (run_cycles > DIV) && ((run_cycles - 1) % DIV == 0); // first at DIV + 1.
      key_high   = key ? key_high + 1 : 0;
      strobe_now = (key_high == `CLOCK_KEY_STABLE + 3); // sync, debounce, then one edge.
      exp_ring   = alarm_ctrl.on && (exp_time == exp_alarm); // uses values before the edge.
      exp_time   = next_time(exp_time, tick_now, set_ctrl.run, strobe_now, set_ctrl.unit,
                             set_ctrl.adj_tens, set_ctrl.adj_units);
      // the alarm steps at any time, so it goes through the stopped branch.
      exp_alarm  = next_time(exp_alarm, 1'b0, 1'b0, strobe_now, alarm_ctrl.unit,
                             alarm_ctrl.adj_tens, alarm_ctrl.adj_units);
      if (tick_now) ticks_seen = ticks_seen + 1;
    end
  end

  // ==============================
  // compare and timeout
  // ==============================

  function automatic string show_time(input clock_pkg::clock_time_t t);
    return $sformatf("%0d%0d:%0d%0d:%0d%0d", t.hour.tens, t.hour.units,
                     t.min.tens, t.min.units, t.sec.tens, t.sec.units);
  endfunction

  task automatic check_time(input string name, input clock_pkg::clock_time_t got,
                            input clock_pkg::clock_time_t want);
    if (got !== want)
    begin
      $display("Error at %0d ns: %s expected %s got %s", $time, name,
               show_time(want), show_time(got));
      errors = errors + 1;
    end
  endtask

  always @(negedge CLK)
  begin
    if (!RESET)
    begin
      checks = checks + 1;
      check_time("time_now", time_now, exp_time);
      check_time("alarm_time", alarm_time, exp_alarm);
      if (ring !== exp_ring)
      begin
        $display("Error at %0d ns: ring expected %b got %b", $time, exp_ring, ring);
        errors = errors + 1;
      end
    end
  end

  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("timeout: the run went past %0d cycles", LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ==============================
  // stimulus helpers
  // ==============================

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic press_key(input int hold);
    key = 1'b1;
    repeat (hold) next_cycle(); // held past the strobe, which must come only once.
    key = 1'b0;
    repeat (4) next_cycle();
  endtask

  task automatic wait_ticks(input int n);
    int target;
    target = ticks_seen + n;
    while (ticks_seen < target) next_cycle();
  endtask

  function automatic int digit_of(input clock_pkg::clock_time_t t,
                                  input clock_pkg::unit_sel_t unit, input bit tens);
    case (unit)
      clock_pkg::UNIT_SEC:  return tens ? int'(t.sec.tens) : int'(t.sec.units);
      clock_pkg::UNIT_MIN:  return tens ? int'(t.min.tens) : int'(t.min.units);
      clock_pkg::UNIT_HOUR: return tens ? int'(t.hour.tens) : int'(t.hour.units);
      default:              return 0;
    endcase
  endfunction

  function automatic bit legal_time(input clock_pkg::clock_time_t t);
    return (t.hour.tens <= 2) && (t.hour.units <= 9) && (t.min.tens <= 5)
        && (t.min.units <= 9) && (t.sec.tens <= 5) && (t.sec.units <= 9)
        && !((t.hour.tens == 2) && (t.hour.units > 3));
  endfunction

  // presses the key until one time or alarm digit reads the target.
  task automatic set_digit(input bit alarm, input clock_pkg::unit_sel_t unit,
                           input bit tens, input int target);
    int guard;
    guard = 0;
    if (alarm)
    begin
      alarm_ctrl.unit      = unit;
      alarm_ctrl.adj_tens  = tens;
      alarm_ctrl.adj_units = !tens;
    end
    else
    begin
      set_ctrl.unit      = unit;
      set_ctrl.adj_tens  = tens;
      set_ctrl.adj_units = !tens;
    end
    while ((digit_of(alarm ? exp_alarm : exp_time, unit, tens) != target) && (guard < 12))
    begin
      press_key(`CLOCK_KEY_STABLE + 6);
      guard = guard + 1;
    end
    if (guard == 12)
    begin
      $display("Error at %0d ns: a digit never reached %0d", $time, target);
      errors = errors + 1;
    end
    set_ctrl.adj_tens    = 1'b0;
    set_ctrl.adj_units   = 1'b0;
    alarm_ctrl.adj_tens  = 1'b0;
    alarm_ctrl.adj_units = 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, errors - errors_mark);
    errors_mark = errors;
  endtask

  // ==============================
  // tests
  // ==============================

  initial
  begin
    int unsigned seed_ret;
    int          n;
    int          mode;
    int          guard;
    int          high_cycles;
    bit          rang;
    seed_ret    = $urandom(32'hc3ba2210);
    key         = 1'b0;
    set_ctrl    = '0;
    alarm_ctrl  = '0;
    cycles      = 0;
    checks      = 0;
    errors      = 0;
    errors_mark = 0;
    wait (RESET == 1'b0);
    next_cycle();

    // reset state, then frozen digits until the first tick.
    check_time("time_now", time_now, '0);
    check_time("alarm_time", alarm_time, '0);
    if (ring !== 1'b0)
    begin
      $display("Error at %0d ns: ring expected 0 got %b", $time, ring);
      errors = errors + 1;
    end
    set_ctrl.run = 1'b1;
    while (ticks_seen == 0)
    begin
      check_time("time_now", time_now, '0);
      next_cycle();
    end
    check_time("time_now", time_now, make_time(0, 0, 1));
    end_test("reset state");

    wait_ticks(61); // carries through :59 into the minutes.
    check_time("time_now", time_now, make_time(0, 1, 2));
    set_ctrl.run = 1'b0;
    end_test("running count");

    set_digit(1'b0, clock_pkg::UNIT_SEC, 1'b1, 5);
    set_digit(1'b0, clock_pkg::UNIT_SEC, 1'b0, 8);
    set_digit(1'b0, clock_pkg::UNIT_MIN, 1'b1, 5);
    set_digit(1'b0, clock_pkg::UNIT_MIN, 1'b0, 9);
    set_digit(1'b0, clock_pkg::UNIT_HOUR, 1'b1, 2);
    set_digit(1'b0, clock_pkg::UNIT_HOUR, 1'b0, 3);
    check_time("time_now", time_now, make_time(23, 59, 58));
    set_ctrl.run = 1'b1;
    wait_ticks(2);
    check_time("time_now", time_now, make_time(0, 0, 0));
    end_test("full wrap");

    // alarm set to 00:00:20 with the clock running from midnight.
    set_digit(1'b1, clock_pkg::UNIT_SEC, 1'b1, 2);
    alarm_ctrl.on = 1'b1;
    guard = 0;
    while ((ring !== 1'b1) && (guard < 40 * DIV))
    begin
      next_cycle();
      guard = guard + 1;
    end
    if (ring !== 1'b1)
    begin
      $display("Error at %0d ns: ring never rose at the alarm time", $time);
      errors = errors + 1;
    end
    high_cycles = 0;
    while ((ring === 1'b1) && (high_cycles < 4 * DIV))
    begin
      high_cycles = high_cycles + 1;
      next_cycle();
    end
    if (high_cycles != DIV)
    begin
      $display("Error at %0d ns: ring high_cycles expected %0d got %0d", $time, DIV,
               high_cycles);
      errors = errors + 1;
    end
    alarm_ctrl.on = 1'b0;
    set_digit(1'b1, clock_pkg::UNIT_SEC, 1'b1, 3);
    rang  = 1'b0;
    guard = 0;
    while ((exp_time != make_time(0, 0, 32)) && (guard < 20 * DIV))
    begin
      rang  = rang | (ring === 1'b1);
      guard = guard + 1;
      next_cycle();
    end
    if (rang)
    begin
      $display("Error at %0d ns: ring rose while the alarm was disabled", $time);
      errors = errors + 1;
    end
    end_test("alarm and ring");

    set_ctrl.run = 1'b0;
    n = 4 + int'($urandom % 9);
    repeat (n)
    begin
      alarm_ctrl.unit      = clock_pkg::unit_sel_t'(2'($urandom % 3));
      mode                 = int'($urandom % 4); // the alarm may step along, or stay.
      alarm_ctrl.adj_tens  = mode[1];
      alarm_ctrl.adj_units = mode[0];
      set_ctrl.unit      = clock_pkg::unit_sel_t'(2'($urandom % 3));
      mode               = 1 + int'($urandom % 3); // tens, units or both.
      set_ctrl.adj_tens  = mode[1];
      set_ctrl.adj_units = mode[0];
      press_key(`CLOCK_KEY_STABLE + 4 + int'($urandom % 7));
    end
    set_ctrl.adj_tens    = 1'b0;
    set_ctrl.adj_units   = 1'b0;
    alarm_ctrl.adj_tens  = 1'b0;
    alarm_ctrl.adj_units = 1'b0;
    if (!legal_time(time_now))
    begin
      $display("Error at %0d ns: time_now left the legal range, got %s", $time,
               show_time(time_now));
      errors = errors + 1;
    end
    if (!legal_time(alarm_time))
    begin
      $display("Error at %0d ns: alarm_time left the legal range, got %s", $time,
               show_time(alarm_time));
      errors = errors + 1;
    end
    end_test("random digit steps");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* digital_clock.f */
+incdir+design
design/clock_pkg.sv
design/tick_prescaler.sv
design/key_pulse.sv
design/base60_counter.sv
design/base24_counter.sv
design/alarm_match.sv
design/clock_top.sv
test/tb_clock_gen.sv
test/tb_clock_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the clock testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_clock_top -f digital_clock.f -o sim_clock \
  && ./obj_dir/sim_clock > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
